// ==== hdl/zip_bus_pkg.sv ====
/*
 * Wishbone bus definitions shared by the fetch, memory and arbiter blocks
 * Bus widths, the local-bus address prefix and the two-view bus word
 */
`default_nettype none

package zip_bus_pkg;

	////////////////////////////////////////
	// Bus geometry
	////////////////////////////////////////

	// Data width of the pipelined Wishbone port
	localparam int BUS_WIDTH = 32;

	// One select line per byte lane
	localparam int SEL_WIDTH = BUS_WIDTH / 8;

	// Byte offset bits dropped from a byte address
	localparam int WBLSB = $clog2(SEL_WIDTH);

	////////////////////////////////////////
	// Address map
	////////////////////////////////////////

	// Top byte of a CPU byte address that selects the local bus
	localparam logic [7:0] LCL_PREFIX = 8'hFF;

	////////////////////////////////////////
	// Bus word views
	////////////////////////////////////////

	// Same 32 bits seen whole, as bytes or as halfwords
	// Index 0 is the most significant lane, big-endian
	typedef union packed {
		logic [BUS_WIDTH-1:0] word;
		logic [0:SEL_WIDTH-1][7:0] bytes;
		logic [0:1][BUS_WIDTH/2-1:0] halves;
	} bus_word_u;

endpackage

`default_nettype wire

// ==== hdl/zip_cpu_pkg.sv ====
/*
 * CPU-side definitions for the fetch and load/store ports
 * Instruction and register widths, memory operation codes
 */
`default_nettype none

package zip_cpu_pkg;

	// Every instruction is one full word
	localparam int INSN_WIDTH = 32;

	// Register file index, 32 registers
	localparam int REG_WIDTH = 5;

	// Memory operation code, size in bits 2:1
	localparam int MEMOP_WIDTH = 3;

	// Size field values
	localparam logic [1:0] MEMOP_WORD = 2'b01;
	localparam logic [1:0] MEMOP_HALF = 2'b10;
	localparam logic [1:0] MEMOP_BYTE = 2'b11;

	// Bit 0 of the code set means a store
	localparam int MEMOP_STORE_BIT = 0;

endpackage

`default_nettype wire

// ==== hdl/prefetch.sv ====
/*
 * Single-fetch instruction prefetch
 * Issues one bus read at a time and holds the word until the core takes it
 */
`default_nettype none
`timescale 1ns/1ns

module prefetch
	import zip_bus_pkg::*, zip_cpu_pkg::*;
#(
	parameter int ADDRESS_WIDTH = 22
) (
	input  logic i_clk,
	input  logic i_reset,
	// Core side
	input  logic i_new_pc,
	input  logic [ADDRESS_WIDTH+WBLSB-1:0] i_pc,
	input  logic i_ready,
	output logic o_valid,
	output logic o_illegal,
	output logic [INSN_WIDTH-1:0] o_insn,
	output logic [ADDRESS_WIDTH+WBLSB-1:0] o_pc,
	// Bus side, read only
	output logic o_wb_cyc,
	output logic o_wb_stb,
	output logic [ADDRESS_WIDTH-1:0] o_wb_addr,
	input  logic i_wb_stall,
	input  logic i_wb_ack,
	input  logic i_wb_err,
	input  bus_word_u i_wb_data
);

	logic start_fetch;
	logic restart;

	// New PC, a pending abort, or a good word just taken
	assign start_fetch = !o_wb_cyc
		&& (i_new_pc || restart || (o_valid && i_ready && !o_illegal));

	////////////////////////////////////////
	// Bus cycle control
	////////////////////////////////////////
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_wb_cyc <= 1'b0;
			o_wb_stb <= 1'b0;
		end
		else if (o_wb_cyc)
		begin
			// Abort on new PC, finish on ack or err
			if (i_new_pc || i_wb_ack || i_wb_err)
			begin
				o_wb_cyc <= 1'b0;
				o_wb_stb <= 1'b0;
			end
			else if (!i_wb_stall)
				o_wb_stb <= 1'b0;
		end
		else if (start_fetch)
		begin
			o_wb_cyc <= 1'b1;
			o_wb_stb <= 1'b1;
		end
	end

	// Aborted cycle needs one idle clock before the refetch
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			restart <= 1'b0;
		else if (o_wb_cyc && i_new_pc)
			restart <= 1'b1;
		else if (start_fetch)
			restart <= 1'b0;
	end

	// Word address of the next read
	always_ff @(posedge i_clk)
	begin
		if (i_new_pc)
			o_wb_addr <= i_pc[ADDRESS_WIDTH+WBLSB-1:WBLSB];
		else if (o_wb_cyc && i_wb_ack)
			o_wb_addr <= o_wb_addr + 1'b1;
	end

	////////////////////////////////////////
	// Returned instruction
	////////////////////////////////////////
	always_ff @(posedge i_clk)
	begin
		if (i_reset || i_new_pc)
		begin
			o_valid <= 1'b0;
			o_illegal <= 1'b0;
		end
		else if (o_wb_cyc && (i_wb_ack || i_wb_err))
		begin
			o_valid <= 1'b1;
			o_illegal <= i_wb_err;
		end
		else if (o_valid && i_ready)
		begin
			o_valid <= 1'b0;
			o_illegal <= 1'b0;
		end
	end

	// Ack in the same clock as a new PC is stale
	always_ff @(posedge i_clk)
	begin
		if (o_wb_cyc && (i_wb_ack || i_wb_err) && !i_new_pc)
		begin
			o_insn <= i_wb_data.word[INSN_WIDTH-1:0];
			o_pc <= {o_wb_addr, {WBLSB{1'b0}}};
		end
	end

endmodule

`default_nettype wire

// ==== hdl/memops.sv ====
/*
 * Non-pipelined load/store unit
 * One bus access per request, word, halfword or byte, big-endian lanes,
 * on the local bus when the address top byte matches the local prefix
 */
`default_nettype none
`timescale 1ns/1ns

module memops
	import zip_bus_pkg::*, zip_cpu_pkg::*;
#(
	parameter int ADDRESS_WIDTH = 22
) (
	input  logic i_clk,
	input  logic i_reset,
	// Core side
	input  logic i_stb,
	input  logic [MEMOP_WIDTH-1:0] i_op,
	input  logic [31:0] i_addr,
	input  logic [31:0] i_data,
	input  logic [REG_WIDTH-1:0] i_oreg,
	output logic o_busy,
	output logic o_valid,
	output logic o_err,
	output logic [REG_WIDTH-1:0] o_wreg,
	output logic [31:0] o_result,
	// Bus side, two cycle lines
	output logic o_wb_cyc_gbl,
	output logic o_wb_cyc_lcl,
	output logic o_wb_stb_gbl,
	output logic o_wb_stb_lcl,
	output logic o_wb_we,
	output logic [ADDRESS_WIDTH-1:0] o_wb_addr,
	output bus_word_u o_wb_data,
	output logic [SEL_WIDTH-1:0] o_wb_sel,
	input  logic i_wb_stall,
	input  logic i_wb_ack,
	input  logic i_wb_err,
	input  bus_word_u i_wb_data
);

	logic cyc;
	logic take;
	logic lcl_req;
	logic [1:0] req_size;
	logic [WBLSB-1:0] req_off;
	logic [SEL_WIDTH-1:0] req_sel;
	bus_word_u req_data;
	// Kept for the load return path
	logic [1:0] r_size;
	logic [WBLSB-1:0] r_off;

	assign cyc = o_wb_cyc_gbl || o_wb_cyc_lcl;
	assign o_busy = cyc;
	assign take = i_stb && !o_busy;

	assign req_size = i_op[2:1];
	assign req_off = i_addr[WBLSB-1:0];
	assign lcl_req = (i_addr[31:24] == LCL_PREFIX);

	////////////////////////////////////////
	// Store lanes and byte selects
	////////////////////////////////////////
	always_comb
	begin
		req_data.word = i_data;
		req_sel = '1;
		case (req_size)
		MEMOP_HALF:
		begin
			// Halfword copied to both halves
			req_data.halves[0] = i_data[15:0];
			req_data.halves[1] = i_data[15:0];
			req_sel = req_off[1] ? 4'b0011 : 4'b1100;
		end
		MEMOP_BYTE:
		begin
			// Byte copied to every lane
			for (int lane = 0; lane < SEL_WIDTH; lane++)
				req_data.bytes[lane] = i_data[7:0];
			// Offset 0 is the top lane
			req_sel = 4'b1000 >> req_off;
		end
		default:
			// Full word
			req_sel = '1;
		endcase
	end

	////////////////////////////////////////
	// Bus cycle control
	////////////////////////////////////////
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_wb_cyc_gbl <= 1'b0;
			o_wb_cyc_lcl <= 1'b0;
			o_wb_stb_gbl <= 1'b0;
			o_wb_stb_lcl <= 1'b0;
		end
		else if (cyc)
		begin
			if (i_wb_ack || i_wb_err)
			begin
				o_wb_cyc_gbl <= 1'b0;
				o_wb_cyc_lcl <= 1'b0;
				o_wb_stb_gbl <= 1'b0;
				o_wb_stb_lcl <= 1'b0;
			end
			else if (!i_wb_stall)
			begin
				// Request accepted, wait for the answer
				o_wb_stb_gbl <= 1'b0;
				o_wb_stb_lcl <= 1'b0;
			end
		end
		else if (take)
		begin
			o_wb_cyc_gbl <= !lcl_req;
			o_wb_stb_gbl <= !lcl_req;
			o_wb_cyc_lcl <= lcl_req;
			o_wb_stb_lcl <= lcl_req;
		end
	end

	// One-clock completion pulses, writes give no valid
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_valid <= 1'b0;
			o_err <= 1'b0;
		end
		else
		begin
			o_valid <= cyc && i_wb_ack && !o_wb_we;
			o_err <= cyc && i_wb_err;
		end
	end

	////////////////////////////////////////
	// Request capture and load return
	////////////////////////////////////////
	always_ff @(posedge i_clk)
	begin
		if (take)
		begin
			o_wb_we <= i_op[MEMOP_STORE_BIT];
			o_wb_addr <= i_addr[ADDRESS_WIDTH+WBLSB-1:WBLSB];
			o_wb_data <= req_data;
			o_wb_sel <= req_sel;
			o_wreg <= i_oreg;
			r_size <= req_size;
			r_off <= req_off;
		end
		if (cyc && i_wb_ack)
		begin
			// Zero-extended lane pick
			case (r_size)
			MEMOP_HALF:
				o_result <= {16'h0, i_wb_data.halves[r_off[1]]};
			MEMOP_BYTE:
				o_result <= {24'h0, i_wb_data.bytes[r_off]};
			default:
				o_result <= i_wb_data.word;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/wbdblpriarb.sv ====
/*
 * Two-master Wishbone arbiter with global and local cycle lines
 * Port A (data) wins an idle bus, port B (fetch) is global, read only
 */
`default_nettype none
`timescale 1ns/1ns

module wbdblpriarb
	import zip_bus_pkg::*;
#(
	parameter int ADDRESS_WIDTH = 22
) (
	input  logic i_clk,
	input  logic i_reset,
	// Port A, memory unit
	input  logic i_a_cyc_gbl,
	input  logic i_a_cyc_lcl,
	input  logic i_a_stb_gbl,
	input  logic i_a_stb_lcl,
	input  logic i_a_we,
	input  logic [ADDRESS_WIDTH-1:0] i_a_addr,
	input  logic [BUS_WIDTH-1:0] i_a_data,
	input  logic [SEL_WIDTH-1:0] i_a_sel,
	output logic o_a_stall,
	output logic o_a_ack,
	output logic o_a_err,
	// Port B, prefetch
	input  logic i_b_cyc,
	input  logic i_b_stb,
	input  logic [ADDRESS_WIDTH-1:0] i_b_addr,
	output logic o_b_stall,
	output logic o_b_ack,
	output logic o_b_err,
	// Shared bus
	output logic o_gbl_cyc,
	output logic o_gbl_stb,
	output logic o_lcl_cyc,
	output logic o_lcl_stb,
	output logic o_we,
	output logic [ADDRESS_WIDTH-1:0] o_addr,
	output logic [BUS_WIDTH-1:0] o_data,
	output logic [SEL_WIDTH-1:0] o_sel,
	input  logic i_stall,
	input  logic i_ack,
	input  logic i_err
);

	logic r_a_owner;
	logic a_cyc;

	assign a_cyc = i_a_cyc_gbl || i_a_cyc_lcl;

	////////////////////////////////////////
	// Ownership
	////////////////////////////////////////
	// Bus parks on A, so A wins when both start together
	// B keeps it for as long as its cycle lasts
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			r_a_owner <= 1'b1;
		else if (!i_b_cyc)
			r_a_owner <= 1'b1;
		else if (!a_cyc)
			r_a_owner <= 1'b0;
	end

	////////////////////////////////////////
	// Request mux
	////////////////////////////////////////
	// Fetch side never reaches the local bus
	assign o_gbl_cyc = r_a_owner ? i_a_cyc_gbl : i_b_cyc;
	assign o_gbl_stb = r_a_owner ? i_a_stb_gbl : i_b_stb;
	assign o_lcl_cyc = r_a_owner && i_a_cyc_lcl;
	assign o_lcl_stb = r_a_owner && i_a_stb_lcl;

	// Fetch reads whole words
	assign o_we = r_a_owner && i_a_we;
	assign o_addr = r_a_owner ? i_a_addr : i_b_addr;
	assign o_sel = r_a_owner ? i_a_sel : '1;

	// Write data only matters for port A
	assign o_data = i_a_data;

	////////////////////////////////////////
	// Response routing
	////////////////////////////////////////
	// Non-owner is held off and sees no answers
	assign o_a_stall = r_a_owner ? i_stall : 1'b1;
	assign o_a_ack = r_a_owner && i_ack;
	assign o_a_err = r_a_owner && i_err;

	assign o_b_stall = r_a_owner ? 1'b1 : i_stall;
	assign o_b_ack = !r_a_owner && i_ack;
	assign o_b_err = !r_a_owner && i_err;

endmodule

`default_nettype wire

// ==== hdl/zipwb_bus.sv ====
/*
 * Bus side of the core top level
 * Prefetch and memory unit share one pipelined Wishbone port
 */
`default_nettype none
`timescale 1ns/1ns

module zipwb_bus
	import zip_bus_pkg::*, zip_cpu_pkg::*;
#(
	parameter int ADDRESS_WIDTH = 22
) (
	input  logic i_clk,
	input  logic i_reset,
	// Fetch port
	input  logic i_pf_new_pc,
	input  logic [ADDRESS_WIDTH+WBLSB-1:0] i_pf_pc,
	input  logic i_pf_ready,
	output logic o_pf_valid,
	output logic [INSN_WIDTH-1:0] o_pf_insn,
	output logic [ADDRESS_WIDTH+WBLSB-1:0] o_pf_pc,
	output logic o_pf_illegal,
	// Memory port
	input  logic i_mem_stb,
	input  logic [MEMOP_WIDTH-1:0] i_mem_op,
	input  logic [31:0] i_mem_addr,
	input  logic [31:0] i_mem_data,
	input  logic [REG_WIDTH-1:0] i_mem_reg,
	output logic o_mem_busy,
	output logic o_mem_valid,
	output logic o_mem_err,
	output logic [REG_WIDTH-1:0] o_mem_wreg,
	output logic [31:0] o_mem_result,
	// Wishbone port
	output logic o_wb_gbl_cyc,
	output logic o_wb_gbl_stb,
	output logic o_wb_lcl_cyc,
	output logic o_wb_lcl_stb,
	output logic o_wb_we,
	output logic [ADDRESS_WIDTH-1:0] o_wb_addr,
	output logic [BUS_WIDTH-1:0] o_wb_data,
	output logic [SEL_WIDTH-1:0] o_wb_sel,
	input  logic i_wb_stall,
	input  logic i_wb_ack,
	input  logic i_wb_err,
	input  logic [BUS_WIDTH-1:0] i_wb_data
);

	// Prefetch to arbiter
	logic pf_cyc, pf_stb, pf_stall, pf_ack, pf_err;
	logic [ADDRESS_WIDTH-1:0] pf_addr;

	// Memory unit to arbiter
	logic mem_cyc_gbl, mem_cyc_lcl, mem_stb_gbl, mem_stb_lcl;
	logic mem_we, mem_stall, mem_ack, mem_err;
	logic [ADDRESS_WIDTH-1:0] mem_addr;
	logic [SEL_WIDTH-1:0] mem_sel;
	bus_word_u mem_data;

	////////////////////////////////////////
	// Requesters
	////////////////////////////////////////
	prefetch #(.ADDRESS_WIDTH(ADDRESS_WIDTH)) u_pf (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_new_pc(i_pf_new_pc), .i_pc(i_pf_pc), .i_ready(i_pf_ready),
		.o_valid(o_pf_valid), .o_illegal(o_pf_illegal),
		.o_insn(o_pf_insn), .o_pc(o_pf_pc),
		.o_wb_cyc(pf_cyc), .o_wb_stb(pf_stb), .o_wb_addr(pf_addr),
		.i_wb_stall(pf_stall), .i_wb_ack(pf_ack), .i_wb_err(pf_err),
		.i_wb_data(i_wb_data)
	);

	memops #(.ADDRESS_WIDTH(ADDRESS_WIDTH)) u_mem (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_stb(i_mem_stb), .i_op(i_mem_op), .i_addr(i_mem_addr),
		.i_data(i_mem_data), .i_oreg(i_mem_reg),
		.o_busy(o_mem_busy), .o_valid(o_mem_valid), .o_err(o_mem_err),
		.o_wreg(o_mem_wreg), .o_result(o_mem_result),
		.o_wb_cyc_gbl(mem_cyc_gbl), .o_wb_cyc_lcl(mem_cyc_lcl),
		.o_wb_stb_gbl(mem_stb_gbl), .o_wb_stb_lcl(mem_stb_lcl),
		.o_wb_we(mem_we), .o_wb_addr(mem_addr),
		.o_wb_data(mem_data), .o_wb_sel(mem_sel),
		.i_wb_stall(mem_stall), .i_wb_ack(mem_ack), .i_wb_err(mem_err),
		.i_wb_data(i_wb_data)
	);

	////////////////////////////////////////
	// Arbiter, data side in priority
	////////////////////////////////////////
	wbdblpriarb #(.ADDRESS_WIDTH(ADDRESS_WIDTH)) u_arb (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_a_cyc_gbl(mem_cyc_gbl), .i_a_cyc_lcl(mem_cyc_lcl),
		.i_a_stb_gbl(mem_stb_gbl), .i_a_stb_lcl(mem_stb_lcl),
		.i_a_we(mem_we), .i_a_addr(mem_addr),
		.i_a_data(mem_data), .i_a_sel(mem_sel),
		.o_a_stall(mem_stall), .o_a_ack(mem_ack), .o_a_err(mem_err),
		.i_b_cyc(pf_cyc), .i_b_stb(pf_stb), .i_b_addr(pf_addr),
		.o_b_stall(pf_stall), .o_b_ack(pf_ack), .o_b_err(pf_err),
		.o_gbl_cyc(o_wb_gbl_cyc), .o_gbl_stb(o_wb_gbl_stb),
		.o_lcl_cyc(o_wb_lcl_cyc), .o_lcl_stb(o_wb_lcl_stb),
		.o_we(o_wb_we), .o_addr(o_wb_addr),
		.o_data(o_wb_data), .o_sel(o_wb_sel),
		.i_stall(i_wb_stall), .i_ack(i_wb_ack), .i_err(i_wb_err)
	);

endmodule

`default_nettype wire

// ==== verification/wb_slave_model.sv ====
/*
 * Pipelined Wishbone memory model for the bus testbench
 * Global and local word memories, pseudo-random stall, one error address
 */
`default_nettype none
`timescale 1ns/1ns

module wb_slave_model
	import zip_bus_pkg::*;
#(
	parameter int ADDRESS_WIDTH = 22,
	parameter logic [ADDRESS_WIDTH-1:0] ERR_WORD = '0
) (
	input  logic i_clk,
	input  logic i_reset,
	input  logic i_gbl_cyc,
	input  logic i_gbl_stb,
	input  logic i_lcl_cyc,
	input  logic i_lcl_stb,
	input  logic i_we,
	input  logic [ADDRESS_WIDTH-1:0] i_addr,
	input  bus_word_u i_data,
	input  logic [SEL_WIDTH-1:0] i_sel,
	output logic o_stall,
	output logic o_ack,
	output logic o_err,
	output bus_word_u o_data
);

	localparam int MEM_AW = 6;
	localparam int MEM_WORDS = 1 << MEM_AW;
	localparam logic [15:0] SEED = 16'd5484;
	localparam logic [31:0] FILL = 32'hA5A5_0000;

	bus_word_u gbl_mem [MEM_WORDS];
	bus_word_u lcl_mem [MEM_WORDS];
	logic [15:0] lfsr = SEED;
	logic [15:0] lfsr_a;
	logic [15:0] lfsr_b;
	logic r_stall = 1'b0;
	logic r_ack = 1'b0;
	logic r_err = 1'b0;
	bus_word_u r_data = '0;
	logic [MEM_AW-1:0] idx;
	logic accept;
	logic is_err;

	// Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// Big-endian lanes, sel bit 3 is byte 0
	function automatic bus_word_u merge_lanes(input bus_word_u old, input bus_word_u wr,
		input logic [SEL_WIDTH-1:0] sel);
		bus_word_u m;
		m = old;
		for (int lane = 0; lane < SEL_WIDTH; lane++)
			if (sel[SEL_WIDTH-1-lane])
				m.bytes[lane] = wr.bytes[lane];
		return m;
	endfunction

	// Preload rule, word address XOR fill
	initial
	begin
		for (int i = 0; i < MEM_WORDS; i++)
		begin
			gbl_mem[i].word = FILL ^ 32'(i);
			lcl_mem[i].word = FILL ^ 32'(i);
		end
	end

	assign lfsr_a = lfsr_step(lfsr);
	assign lfsr_b = lfsr_step(lfsr_a);
	assign idx = i_addr[MEM_AW-1:0];
	assign accept = ((i_gbl_cyc && i_gbl_stb) || (i_lcl_cyc && i_lcl_stb)) && !r_stall;
	// Error address lives on the global bus only
	assign is_err = i_gbl_cyc && (i_addr == ERR_WORD);

	////////////////////////////////////////
	// Handshake and memory access
	////////////////////////////////////////
	always @(posedge i_clk)
	begin
		if (i_reset)
		begin
			lfsr <= SEED;
			r_stall <= 1'b0;
			r_ack <= 1'b0;
			r_err <= 1'b0;
		end
		else
		begin
			lfsr <= lfsr_b;
			// Two fresh bits, stall about one cycle in four
			r_stall <= lfsr_a[0] & lfsr_b[0];
			r_ack <= accept && !is_err;
			r_err <= accept && is_err;
		end
		if (accept && !is_err)
		begin
			if (i_lcl_cyc)
			begin
				if (i_we)
					lcl_mem[idx] <= merge_lanes(lcl_mem[idx], i_data, i_sel);
				r_data <= lcl_mem[idx];
			end
			else
			begin
				if (i_we)
					gbl_mem[idx] <= merge_lanes(gbl_mem[idx], i_data, i_sel);
				r_data <= gbl_mem[idx];
			end
		end
	end

	assign o_stall = r_stall;
	assign o_ack = r_ack;
	assign o_err = r_err;
	assign o_data = r_data;

endmodule

`default_nettype wire

// ==== verification/tb_zipwb_bus.sv ====
/*
 * Testbench for the shared-bus top level
 * Table-driven fetch, load and store traffic against a Wishbone memory model
 */
`default_nettype none
`timescale 1ns/1ns

module tb_zipwb_bus
	import zip_bus_pkg::*, zip_cpu_pkg::*;
();

	localparam int ADDRESS_WIDTH = 22;
	localparam int PC_WIDTH = ADDRESS_WIDTH + WBLSB;
	localparam logic [31:0] ERR_ADDR = 32'h0000_00F0;
	localparam logic [31:0] FILL = 32'hA5A5_0000;
	// Operation codes as size then store bit
	localparam logic [MEMOP_WIDTH-1:0] OP_LW = {MEMOP_WORD, 1'b0};
	localparam logic [MEMOP_WIDTH-1:0] OP_SW = {MEMOP_WORD, 1'b1};
	localparam logic [MEMOP_WIDTH-1:0] OP_LH = {MEMOP_HALF, 1'b0};
	localparam logic [MEMOP_WIDTH-1:0] OP_SH = {MEMOP_HALF, 1'b1};
	localparam logic [MEMOP_WIDTH-1:0] OP_LB = {MEMOP_BYTE, 1'b0};
	localparam logic [MEMOP_WIDTH-1:0] OP_SB = {MEMOP_BYTE, 1'b1};

	typedef enum logic [1:0] {K_FETCH, K_LOAD, K_STORE, K_BOTH} kind_e;

	// Stimulus row
	// Data holds the fetch PC for K_BOTH
	typedef struct packed {
		kind_e kind;
		logic [MEMOP_WIDTH-1:0] op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [REG_WIDTH-1:0] rix;
		bus_word_u exp_val;
	} row_t;

	logic i_clk, i_reset;
	logic i_pf_new_pc, i_pf_ready;
	logic [PC_WIDTH-1:0] i_pf_pc;
	logic o_pf_valid, o_pf_illegal;
	logic [INSN_WIDTH-1:0] o_pf_insn;
	logic [PC_WIDTH-1:0] o_pf_pc;
	logic i_mem_stb;
	logic [MEMOP_WIDTH-1:0] i_mem_op;
	logic [31:0] i_mem_addr, i_mem_data;
	logic [REG_WIDTH-1:0] i_mem_reg;
	logic o_mem_busy, o_mem_valid, o_mem_err;
	logic [REG_WIDTH-1:0] o_mem_wreg;
	logic [31:0] o_mem_result;
	logic o_wb_gbl_cyc, o_wb_gbl_stb, o_wb_lcl_cyc, o_wb_lcl_stb, o_wb_we;
	logic [ADDRESS_WIDTH-1:0] o_wb_addr;
	logic [BUS_WIDTH-1:0] o_wb_data, i_wb_data;
	logic [SEL_WIDTH-1:0] o_wb_sel;
	logic i_wb_stall, i_wb_ack, i_wb_err;

	row_t rows[$];
	int value_errors = 0;
	int bus_errors = 0;
	int cycles = 0;
	int cycle_limit = 0;

	zipwb_bus #(.ADDRESS_WIDTH(ADDRESS_WIDTH)) UUT (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_pf_new_pc(i_pf_new_pc), .i_pf_pc(i_pf_pc), .i_pf_ready(i_pf_ready),
		.o_pf_valid(o_pf_valid), .o_pf_insn(o_pf_insn), .o_pf_pc(o_pf_pc),
		.o_pf_illegal(o_pf_illegal),
		.i_mem_stb(i_mem_stb), .i_mem_op(i_mem_op), .i_mem_addr(i_mem_addr),
		.i_mem_data(i_mem_data), .i_mem_reg(i_mem_reg),
		.o_mem_busy(o_mem_busy), .o_mem_valid(o_mem_valid), .o_mem_err(o_mem_err),
		.o_mem_wreg(o_mem_wreg), .o_mem_result(o_mem_result),
		.o_wb_gbl_cyc(o_wb_gbl_cyc), .o_wb_gbl_stb(o_wb_gbl_stb),
		.o_wb_lcl_cyc(o_wb_lcl_cyc), .o_wb_lcl_stb(o_wb_lcl_stb),
		.o_wb_we(o_wb_we), .o_wb_addr(o_wb_addr),
		.o_wb_data(o_wb_data), .o_wb_sel(o_wb_sel),
		.i_wb_stall(i_wb_stall), .i_wb_ack(i_wb_ack), .i_wb_err(i_wb_err),
		.i_wb_data(i_wb_data)
	);

	wb_slave_model #(
		.ADDRESS_WIDTH(ADDRESS_WIDTH),
		.ERR_WORD(ERR_ADDR[PC_WIDTH-1:WBLSB])
	) u_slave (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_gbl_cyc(o_wb_gbl_cyc), .i_gbl_stb(o_wb_gbl_stb),
		.i_lcl_cyc(o_wb_lcl_cyc), .i_lcl_stb(o_wb_lcl_stb),
		.i_we(o_wb_we), .i_addr(o_wb_addr), .i_data(o_wb_data), .i_sel(o_wb_sel),
		.o_stall(i_wb_stall), .o_ack(i_wb_ack), .o_err(i_wb_err), .o_data(i_wb_data)
	);

	////////////////////////////////////////
	// Clock, timeout and bus line monitor
	////////////////////////////////////////
	initial
	begin
		i_clk = 1'b0;
		forever #4 i_clk = !i_clk;
	end

	always @(posedge i_clk)
	begin
		cycles++;
		if (cycle_limit != 0 && cycles >= cycle_limit)
		begin
			$display("Timeout after %0d cycles, a request never completed", cycles);
			$display("Checks failed");
			$finish;
		end
	end

	// Global and local cycles never overlap, sampled mid-cycle
	always @(negedge i_clk)
	begin
		if (!i_reset && o_wb_gbl_cyc && o_wb_lcl_cyc)
		begin
			bus_errors++;
			$display("Global and local cycle lines both high at %0t", $time);
		end
	end

	////////////////////////////////////////
	// Expected values and compare tasks
	////////////////////////////////////////
	// Memory model preload rule from a byte address
	function automatic bus_word_u preload_word(input logic [31:0] byte_addr);
		bus_word_u w;
		w.word = FILL ^ 32'(byte_addr[PC_WIDTH-1:WBLSB]);
		return w;
	endfunction

	task automatic check_word(input string what, input bus_word_u got, input bus_word_u exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("ERROR %0t: %s got %h expected %h", $time, what, got.word, exp.word);
		end
	endtask

	task automatic check_reg(input string what, input logic [REG_WIDTH-1:0] got,
		input logic [REG_WIDTH-1:0] exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("ERROR %0t: %s got r%0d expected r%0d", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("ERROR %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	// Advance to 1 ns after the next rising edge
	task automatic step();
		@(posedge i_clk);
		#1;
	endtask

	task automatic check_idle(input string what);
		check_flag(what, o_wb_gbl_cyc | o_wb_gbl_stb | o_wb_lcl_cyc | o_wb_lcl_stb
			| o_pf_valid | o_mem_busy | o_mem_valid | o_mem_err, 1'b0);
	endtask

	task automatic add_row(input kind_e kind, input logic [MEMOP_WIDTH-1:0] op,
		input logic [31:0] addr, input logic [31:0] data,
		input logic [REG_WIDTH-1:0] rix, input logic [31:0] exp);
		row_t r;
		r.kind = kind;
		r.op = op;
		r.addr = addr;
		r.data = data;
		r.rix = rix;
		r.exp_val.word = exp;
		rows.push_back(r);
	endtask

	////////////////////////////////////////
	// Stimulus table
	////////////////////////////////////////
	task automatic build_table();
		// Sequential fetch with a hold
		add_row(K_FETCH, OP_LW, 32'h0000_0080, 32'h0, 5'd0, 32'hA5A5_0020);
		// Word, byte and halfword stores into word 8 in big-endian lanes
		add_row(K_STORE, OP_SW, 32'h0000_0020, 32'h1122_3344, 5'd0, 32'h0);
		add_row(K_LOAD, OP_LW, 32'h0000_0020, 32'h0, 5'd1, 32'h1122_3344);
		add_row(K_STORE, OP_SB, 32'h0000_0021, 32'h0000_00AB, 5'd0, 32'h0);
		add_row(K_LOAD, OP_LW, 32'h0000_0020, 32'h0, 5'd2, 32'h11AB_3344);
		add_row(K_STORE, OP_SH, 32'h0000_0022, 32'h0000_CDEF, 5'd0, 32'h0);
		add_row(K_LOAD, OP_LW, 32'h0000_0020, 32'h0, 5'd3, 32'h11AB_CDEF);
		// Narrow loads return zero-extended lanes
		add_row(K_LOAD, OP_LB, 32'h0000_0023, 32'h0, 5'd7, 32'h0000_00EF);
		add_row(K_LOAD, OP_LH, 32'h0000_0020, 32'h0, 5'd9, 32'h0000_11AB);
		add_row(K_LOAD, OP_LB, 32'h0000_0021, 32'h0, 5'd10, 32'h0000_00AB);
		// Byte at offset 0 hits the top lane of a preloaded word
		add_row(K_STORE, OP_SB, 32'h0000_0030, 32'h0000_0055, 5'd0, 32'h0);
		add_row(K_LOAD, OP_LW, 32'h0000_0030, 32'h0, 5'd4, 32'h55A5_000C);
		// Local bus
		add_row(K_LOAD, OP_LW, 32'hFF00_0040, 32'h0, 5'd5, 32'hA5A5_0010);
		add_row(K_STORE, OP_SW, 32'hFF00_0044, 32'hDEAD_BEEF, 5'd0, 32'h0);
		add_row(K_LOAD, OP_LW, 32'hFF00_0044, 32'h0, 5'd6, 32'hDEAD_BEEF);
		add_row(K_LOAD, OP_LH, 32'hFF00_0046, 32'h0, 5'd13, 32'h0000_BEEF);
		// Same offset on the global side keeps its preload
		add_row(K_LOAD, OP_LW, 32'h0000_0044, 32'h0, 5'd8, 32'hA5A5_0011);
		// Load at 0x50 and fetch at 0x60 in the same cycle
		add_row(K_BOTH, OP_LW, 32'h0000_0050, 32'h0000_0060, 5'd11, 32'hA5A5_0014);
		// Marked error address
		add_row(K_LOAD, OP_LW, ERR_ADDR, 32'h0, 5'd12, 32'h0);
		add_row(K_FETCH, OP_LW, ERR_ADDR, 32'h0, 5'd0, 32'h0);
	endtask

	////////////////////////////////////////
	// Row runners
	////////////////////////////////////////
	task automatic take_insn(input logic [31:0] pc, input bus_word_u exp,
		input logic exp_illegal, input logic hold);
		while (!o_pf_valid)
			step();
		check_flag("fetch illegal", o_pf_illegal, exp_illegal);
		if (!exp_illegal)
			check_word("fetch insn", o_pf_insn, exp);
		check_word("fetch pc", 32'(o_pf_pc), pc);
		if (hold)
		begin
			repeat (3)
			begin
				step();
				check_flag("held valid", o_pf_valid, 1'b1);
				check_word("held insn", o_pf_insn, exp);
				check_word("held pc", 32'(o_pf_pc), pc);
				// Nothing taken means no new read
				check_flag("fetch while held", o_wb_gbl_cyc, 1'b0);
			end
		end
		i_pf_ready = 1'b1;
		step();
		i_pf_ready = 1'b0;
	endtask

	task automatic run_fetch(input row_t r);
		logic is_err;
		logic [31:0] pc;
		is_err = (r.addr == ERR_ADDR);
		i_pf_new_pc = 1'b1;
		i_pf_pc = r.addr[PC_WIDTH-1:0];
		step();
		i_pf_new_pc = 1'b0;
		for (int k = 0; k < (is_err ? 1 : 3); k++)
		begin
			pc = r.addr + 32'(4 * k);
			take_insn(pc, (k == 0) ? r.exp_val : preload_word(pc), is_err, k == 0 && !is_err);
		end
		// Fetch stays parked after an error
		if (is_err)
			repeat (3)
			begin
				step();
				check_flag("fetch after bus error", o_wb_gbl_cyc, 1'b0);
			end
	endtask

	task automatic issue_mem(input row_t r);
		i_mem_stb = 1'b1;
		i_mem_op = r.op;
		i_mem_addr = r.addr;
		i_mem_data = r.data;
		i_mem_reg = r.rix;
	endtask

	task automatic run_mem(input row_t r);
		logic exp_err;
		logic got_valid;
		logic got_err;
		exp_err = (r.addr == ERR_ADDR);
		got_valid = 1'b0;
		got_err = 1'b0;
		while (o_mem_busy)
			step();
		issue_mem(r);
		step();
		i_mem_stb = 1'b0;
		if (r.op[MEMOP_STORE_BIT])
		begin
			// Write ends with busy falling and never with valid
			while (o_mem_busy)
			begin
				got_valid |= o_mem_valid;
				got_err |= o_mem_err;
				step();
			end
			check_flag("store valid", got_valid | o_mem_valid, 1'b0);
			check_flag("store error", got_err | o_mem_err, 1'b0);
		end
		else
		begin
			while (!o_mem_valid && !o_mem_err)
				step();
			check_flag("load valid", o_mem_valid, !exp_err);
			check_flag("load error", o_mem_err, exp_err);
			if (!exp_err)
			begin
				check_word("load result", o_mem_result, r.exp_val);
				check_reg("load register", o_mem_wreg, r.rix);
			end
		end
	endtask

	task automatic run_both(input row_t r);
		logic mem_done;
		bus_word_u got_result;
		logic [REG_WIDTH-1:0] got_reg;
		mem_done = 1'b0;
		got_result = '0;
		got_reg = '0;
		while (o_mem_busy)
			step();
		issue_mem(r);
		i_pf_new_pc = 1'b1;
		i_pf_pc = r.data[PC_WIDTH-1:0];
		step();
		i_mem_stb = 1'b0;
		i_pf_new_pc = 1'b0;
		// Valid is a one-clock pulse caught while the fetch finishes
		while (!(mem_done && o_pf_valid))
		begin
			step();
			if (o_mem_valid || o_mem_err)
			begin
				mem_done = 1'b1;
				check_flag("concurrent load error", o_mem_err, 1'b0);
				got_result = o_mem_result;
				got_reg = o_mem_wreg;
			end
		end
		check_word("concurrent load result", got_result, r.exp_val);
		check_reg("concurrent load register", got_reg, r.rix);
		take_insn(r.data, preload_word(r.data), 1'b0, 1'b0);
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////
	initial
	begin
		i_reset = 1'b1;
		i_pf_new_pc = 1'b0;
		i_pf_pc = '0;
		i_pf_ready = 1'b0;
		i_mem_stb = 1'b0;
		i_mem_op = '0;
		i_mem_addr = '0;
		i_mem_data = '0;
		i_mem_reg = '0;
		build_table();
		cycle_limit = rows.size() * 64;
		repeat (3)
		begin
			step();
			check_idle("idle during reset");
		end
		i_reset = 1'b0;
		step();
		check_idle("idle after reset");
		foreach (rows[i])
		begin
			case (rows[i].kind)
			K_FETCH: run_fetch(rows[i]);
			K_BOTH: run_both(rows[i]);
			default: run_mem(rows[i]);
			endcase
		end
		repeat (2)
			step();
		$display("Done: %0d value errors, %0d bus errors", value_errors, bus_errors);
		if (value_errors == 0 && bus_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
hdl/zip_bus_pkg.sv
hdl/zip_cpu_pkg.sv
hdl/prefetch.sv
hdl/memops.sv
hdl/wbdblpriarb.sv
hdl/zipwb_bus.sv
verification/wb_slave_model.sv
verification/tb_zipwb_bus.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing -Wno-fatal
LINT_FLAGS = --lint-only -Wall
TOP = tb_zipwb_bus
RTL_TOP = zipwb_bus
FILELIST = src.f
OBJ_DIR = obj_dir
PASS_MSG = All checks passed
RTL_SRCS = $(shell grep '^hdl/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)
